//--- files.f
+incdir+tests
design/keccak_pkg.sv
design/keccak_theta_rho_pi.sv
design/keccak_chi_iota.sv
design/keccak_round_ctrl.sv
design/keccak_perm.sv
tests/tb_keccak_perm.sv

//--- Makefile
# Verilator build and run for the Keccak-f[1600] permutation core
TOP := tb_keccak_perm
OBJ := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

# Exit status of the simulation binary is the pass or fail result
test:
	verilator --binary --timing --assert -f files.f \
		--top-module $(TOP) -Mdir $(OBJ) -o $(TOP)
	./$(OBJ)/$(TOP)

clean:
	rm -rf $(OBJ)

//--- tests/keccak_model.svh
// Keccak-f[1600] reference model for the testbench
// One round and the full 24-round permutation on the flat
// 1600-bit state, from the FIPS 202 step definitions. Rho
// offsets and round constants are generated by the standard's
// own algorithms
`ifndef KECCAK_MODEL_SVH
`define KECCAK_MODEL_SVH

// Left rotation of one lane
function automatic logic [63:0] rotl_lane(logic [63:0] v, int n);
  int k;
  k = n % 64;
  if (k == 0) return v;
  return (v << k) | (v >> (64 - k));
endfunction

// rc(t) from the 8-bit LFSR, FIPS 202 algorithm 5
function automatic logic lfsr_bit(int t);
  logic [8:0] r;
  int i;
  int n;
  n = t % 255;
  if (n == 0) return 1'b1;
  r = 9'h001;
  for (i = 1; i <= n; i++) begin
    // Prepend a zero, feed back from the dropped bit
    r = {r[7:0], 1'b0};
    r[0] = r[0] ^ r[8];
    r[4] = r[4] ^ r[8];
    r[5] = r[5] ^ r[8];
    r[6] = r[6] ^ r[8];
    r[8] = 1'b0;
  end
  return r[0];
endfunction

// Iota constant, bits 2^j - 1 only
function automatic logic [63:0] round_constant(int ir);
  logic [63:0] rc;
  int j;
  rc = '0;
  for (j = 0; j <= 6; j++) begin
    rc[(1 << j) - 1] = lfsr_bit(j + 7 * ir);
  end
  return rc;
endfunction

// One full round Rnd(A, ir)
function automatic logic [1599:0] apply_round(logic [1599:0] s, int ir);
  logic [63:0] a [5][5];
  logic [63:0] b [5][5];
  logic [63:0] c [5];
  logic [63:0] d [5];
  logic [1599:0] r;
  int x;
  int y;
  int nx;
  int t;
  for (y = 0; y < 5; y++)
    for (x = 0; x < 5; x++)
      a[x][y] = s[64*(5*y+x) +: 64];
  // Theta
  for (x = 0; x < 5; x++)
    c[x] = a[x][0] ^ a[x][1] ^ a[x][2] ^ a[x][3] ^ a[x][4];
  for (x = 0; x < 5; x++)
    d[x] = c[(x + 4) % 5] ^ rotl_lane(c[(x + 1) % 5], 1);
  for (y = 0; y < 5; y++)
    for (x = 0; x < 5; x++)
      a[x][y] = a[x][y] ^ d[x];
  // Rho, walking the (x,y) orbit from (1,0)
  b = a;
  x = 1;
  y = 0;
  for (t = 0; t < 24; t++) begin
    b[x][y] = rotl_lane(a[x][y], (t + 1) * (t + 2) / 2);
    nx = y;
    y = (2 * x + 3 * y) % 5;
    x = nx;
  end
  // Pi
  for (y = 0; y < 5; y++)
    for (x = 0; x < 5; x++)
      a[x][y] = b[(x + 3 * y) % 5][x];
  // Chi
  for (y = 0; y < 5; y++)
    for (x = 0; x < 5; x++)
      b[x][y] = a[x][y] ^ (~a[(x + 1) % 5][y] & a[(x + 2) % 5][y]);
  // Iota
  b[0][0] = b[0][0] ^ round_constant(ir);
  for (y = 0; y < 5; y++)
    for (x = 0; x < 5; x++)
      r[64*(5*y+x) +: 64] = b[x][y];
  return r;
endfunction

// All 24 rounds
function automatic logic [1599:0] permute_state(logic [1599:0] s);
  int ir;
  for (ir = 0; ir < 24; ir++) begin
    s = apply_round(s, ir);
  end
  return s;
endfunction

`endif

//--- tests/tb_keccak_perm.sv
// Testbench for the Keccak-f[1600] permutation core
// Runs a table of fixed and random states through the DUT,
// checks results against the reference model, the done
// latency, busy behavior, ignored starts and result hold
module tb_keccak_perm;
  timeunit 1ns;
  timeprecision 1ps;
  import keccak_pkg::*;

  `include "keccak_model.svh"

  ////////////////////////////////////////////////////////////
  // DUT and clock
  ////////////////////////////////////////////////////////////

  logic   clk = 1'b0;
  logic   rst;
  logic   start;
  state_t state_in;
  logic   busy;
  logic   done;
  state_t state_out;

  always #5 clk = ~clk;

  keccak_perm DUT (
    .clk_i   (clk),
    .rst_i   (rst),
    .start_i (start),
    .state_i (state_in),
    .busy_o  (busy),
    .done_o  (done),
    .state_o (state_out)
  );

  ////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////

  typedef enum logic {FIXED, RANDOM} kind_e;

  typedef struct packed {
    kind_e       kind;
    state_t      fixed;
    logic        has_kat;   // expected lane (0,0) known
    logic [63:0] kat;
    logic [5:0]  inject_at; // cycle of an extra start, 0 for none
  } stim_t;

  localparam int NumCases = 7;
  stim_t cases [NumCases];

  // Xorshift64 state
  logic [63:0] rng = 64'd41;

  function automatic logic [63:0] xorshift64();
    logic [63:0] v;
    v = rng;
    v = v ^ (v << 13);
    v = v ^ (v >> 7);
    v = v ^ (v << 17);
    rng = v;
    return v;
  endfunction

  function automatic state_t random_state();
    state_t s;
    int i;
    for (i = 0; i < 25; i++) begin
      s[64*i +: 64] = xorshift64();
    end
    return s;
  endfunction

  // Distinct byte per lane, no symmetry between lanes
  function automatic state_t lane_pattern();
    state_t s;
    int i;
    for (i = 0; i < 25; i++) begin
      s[64*i +: 64] = {8{8'(i + 1)}} ^ 64'h0123_4567_89AB_CDEF;
    end
    return s;
  endfunction

  task automatic set_case(input int i, input kind_e k, input state_t s,
                          input logic has_kat, input logic [63:0] kat, input int inj);
    cases[i].kind      = k;
    cases[i].fixed     = s;
    cases[i].has_kat   = has_kat;
    cases[i].kat       = kat;
    cases[i].inject_at = 6'(inj);
  endtask

  task automatic fill_table();
    set_case(0, FIXED, '0, 1'b1, 64'hF125_8F79_40E1_DDE7, 0);
    set_case(1, FIXED, '1, 1'b0, '0, 0);
    set_case(2, FIXED, lane_pattern(), 1'b0, '0, 0);
    set_case(3, RANDOM, '0, 1'b0, '0, 0);
    // Extra starts early, mid run and on the last round
    set_case(4, RANDOM, '0, 1'b0, '0, 1);
    set_case(5, RANDOM, '0, 1'b0, '0, 12);
    set_case(6, RANDOM, '0, 1'b0, '0, 24);
  endtask

  ////////////////////////////////////////////////////////////
  // Checks and waits
  ////////////////////////////////////////////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      fail_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, expected));
    end
  endtask

  // Lane by lane, so an error names the lane
  task automatic check_state(input state_t got, input state_t expected);
    int x;
    int y;
    for (y = 0; y < 5; y++) begin
      for (x = 0; x < 5; x++) begin
        check_value($sformatf("state_o lane (%0d,%0d)", x, y),
                    got[64*(5*y+x) +: 64], expected[64*(5*y+x) +: 64]);
      end
    end
  endtask

  // Entered on the falling edge where start was driven
  task automatic wait_for_done(input int inject_at, input state_t inject_state,
                               output int cycles);
    int n;
    n = 0;
    while (done !== 1'b1) begin
      @(negedge clk);
      n++;
      start = (n == inject_at);
      if (n == inject_at) state_in = inject_state;
      if (n > 60) begin
        fail_run("timeout: done_o did not rise within 60 cycles of start");
      end
      // Busy through the run, low once done shows
      if (done !== 1'b1) begin
        check_value("busy_o", 64'(busy), 64'h1);
      end else begin
        check_value("busy_o", 64'(busy), 64'h0);
      end
    end
    // Start edge lies inside the first counted cycle
    cycles = n - 1;
  endtask

  // Result must survive input changes without a start
  task automatic check_hold(input state_t expected);
    int k;
    for (k = 1; k <= 3; k++) begin
      state_in = random_state();
      @(negedge clk);
      check_value("done_o", 64'(done), 64'h0);
      check_value("busy_o", 64'(busy), 64'h0);
      check_state(state_out, expected);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int     i;
    int     cycles;
    state_t s;
    state_t other;
    state_t expected;
    rst      = 1'b1;
    start    = 1'b0;
    state_in = '0;
    fill_table();

    // Reset for 3 cycles
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_value("busy_o", 64'(busy), 64'h0);
    check_value("done_o", 64'(done), 64'h0);
    check_state(state_out, '0);

    for (i = 0; i < NumCases; i++) begin
      if (cases[i].kind == RANDOM) begin
        s = random_state();
      end else begin
        s = cases[i].fixed;
      end
      other    = random_state();
      expected = permute_state(s);

      start    = 1'b1;
      state_in = s;
      wait_for_done(int'(cases[i].inject_at), other, cycles);

      check_value("done_o latency", 64'(cycles), 64'd24);
      check_state(state_out, expected);
      if (cases[i].has_kat) begin
        check_value("state_o lane (0,0)", state_out[63:0], cases[i].kat);
      end
      check_hold(expected);
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- design/keccak_perm.sv
// Keccak-f[1600] permutation core
// Holds the state register and applies one full round per
// clock. A start pulse loads state_i, 24 rounds later done
// pulses and state_o carries the permuted state until the
// next accepted start
module keccak_perm (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               start_i,
  input  keccak_pkg::state_t state_i,
  output logic               busy_o,
  output logic               done_o,
  output keccak_pkg::state_t state_o
);
  import keccak_pkg::*;

  // Sequencer control for this cycle
  rnd_ctl_t ctl;

  // State register and round datapath nets
  box_t box_q;
  box_t trp_data;
  box_t round_data;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  keccak_round_ctrl u_ctrl (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .start_i (start_i),
    .ctl_o   (ctl),
    .busy_o  (busy_o),
    .done_o  (done_o)
  );

  ////////////////////////////////////////////////////////////
  // State register
  ////////////////////////////////////////////////////////////

  // Cleared on reset so state_o reads zero before first run
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      box_q <= '0;
    end else if (ctl.load) begin
      box_q <= to_box(state_i);
    end else if (ctl.advance) begin
      box_q <= round_data;
    end
  end

  // Flat view of the register
  assign state_o = to_state(box_q);

  ////////////////////////////////////////////////////////////
  // Round datapath
  ////////////////////////////////////////////////////////////

  // Theta, rho, pi
  keccak_theta_rho_pi u_theta_rho_pi (
    .state_i (box_q),
    .state_o (trp_data)
  );

  // Chi, iota
  keccak_chi_iota u_chi_iota (
    .state_i (trp_data),
    .rnd_i   (ctl.rnd),
    .state_o (round_data)
  );

  // Loading a new state mid-run would corrupt the permutation
  load_vs_advance_a: assert property (@(posedge clk_i) disable iff (rst_i)
    !(ctl.load && ctl.advance));

endmodule

//--- design/keccak_round_ctrl.sv
// Keccak round sequencer
// IDLE/RUN state machine with a round counter. A start in
// IDLE loads the state, then 24 advance cycles follow with
// an incrementing round index, then done pulses once
module keccak_round_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 start_i,
  output keccak_pkg::rnd_ctl_t ctl_o,
  output logic                 busy_o,
  output logic                 done_o
);
  import keccak_pkg::*;

  ctrl_state_e     state_q;
  ctrl_state_e     state_d;
  logic [RndW-1:0] rnd_q;
  logic            last_rnd;
  logic            accept;
  logic            done_q;

  // Start only taken while idle, busy starts are dropped
  assign accept = (state_q == IDLE) && start_i;

  // Final round is being written this cycle
  assign last_rnd = (state_q == RUN) && (rnd_q == RndW'(NumRounds - 1));

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (accept) state_d = RUN;
      RUN:     if (last_rnd) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      rnd_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= last_rnd;
      // Round index, restarts from zero each permutation
      if (accept || last_rnd) begin
        rnd_q <= '0;
      end else if (state_q == RUN) begin
        rnd_q <= rnd_q + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  assign ctl_o.load    = accept;
  assign ctl_o.advance = (state_q == RUN);
  assign ctl_o.rnd     = rnd_q;

  assign busy_o = (state_q == RUN);
  assign done_o = done_q;

  // Index must address a valid constant while running
  rnd_in_range_a: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_q == RUN) |-> (rnd_q < RndW'(NumRounds)));

  // Done is a single-cycle pulse
  done_pulse_a: assert property (@(posedge clk_i) disable iff (rst_i)
    done_o |=> !done_o);

endmodule

//--- design/keccak_chi_iota.sv
// Keccak round, second half
// Chi nonlinear row mixing, then iota round constant
// injection into lane (0,0). Purely combinational
module keccak_chi_iota (
  input  keccak_pkg::box_t              state_i,
  input  logic [keccak_pkg::RndW-1:0]   rnd_i,
  output keccak_pkg::box_t              state_o
);
  import keccak_pkg::*;

  // Chi result before iota
  box_t chi_data;

  // Constant selected for this round
  lane_t rc;

  ////////////////////////////////////////////////////////////
  // Chi
  ////////////////////////////////////////////////////////////

  // Each row of five lanes handled independently
  for (genvar x = 0; x < 5; x++) begin : g_chi_x
    for (genvar y = 0; y < 5; y++) begin : g_chi_y
      assign chi_data[x][y] = state_i[x][y]
                            ^ (~state_i[(x + 1) % 5][y] & state_i[(x + 2) % 5][y]);
    end
  end

  ////////////////////////////////////////////////////////////
  // Iota
  ////////////////////////////////////////////////////////////

  // Index stays below NumRounds, guarded in the controller
  assign rc = round_const[rnd_i];

  always_comb begin
    state_o = chi_data;
    // Only lane (0,0) takes the constant
    state_o[0][0] = chi_data[0][0] ^ rc;
  end

endmodule

//--- design/keccak_theta_rho_pi.sv
// Keccak round, first half
// Theta column parity mixing, then rho lane rotation,
// then pi lane rearrangement. Purely combinational
module keccak_theta_rho_pi (
  input  keccak_pkg::box_t state_i,
  output keccak_pkg::box_t state_o
);
  import keccak_pkg::*;

  // Column parities and theta mixing terms
  plane_t parity;
  plane_t mix;

  // Intermediate boxes
  box_t theta_data;
  box_t rho_data;

  ////////////////////////////////////////////////////////////
  // Theta
  ////////////////////////////////////////////////////////////

  for (genvar x = 0; x < 5; x++) begin : g_parity
    // XOR of the five lanes in column x
    assign parity[x] = state_i[x][0] ^ state_i[x][1] ^ state_i[x][2]
                     ^ state_i[x][3] ^ state_i[x][4];
  end

  for (genvar x = 0; x < 5; x++) begin : g_mix
    // Column x-1, plus column x+1 rotated by one along z
    assign mix[x] = parity[(x + 4) % 5]
                  ^ {parity[(x + 1) % 5][LaneW-2:0], parity[(x + 1) % 5][LaneW-1]};
  end

  for (genvar x = 0; x < 5; x++) begin : g_theta_x
    for (genvar y = 0; y < 5; y++) begin : g_theta_y
      assign theta_data[x][y] = state_i[x][y] ^ mix[x];
    end
  end

  ////////////////////////////////////////////////////////////
  // Rho
  ////////////////////////////////////////////////////////////

  // Left rotation by the table offset mod lane width
  // Zero offset falls out naturally, right shift by LaneW is zero
  for (genvar x = 0; x < 5; x++) begin : g_rho_x
    for (genvar y = 0; y < 5; y++) begin : g_rho_y
      assign rho_data[x][y] =
          (theta_data[x][y] << (rho_offset[5*x+y] % LaneW))
        | (theta_data[x][y] >> (LaneW - (rho_offset[5*x+y] % LaneW)));
    end
  end

  ////////////////////////////////////////////////////////////
  // Pi
  ////////////////////////////////////////////////////////////

  // Lane (x,y) moves to (y, 2x+3y mod 5)
  // Map is a permutation, every output lane driven once
  for (genvar x = 0; x < 5; x++) begin : g_pi_x
    for (genvar y = 0; y < 5; y++) begin : g_pi_y
      assign state_o[y][(2*x + 3*y) % 5] = rho_data[x][y];
    end
  end

endmodule

//--- design/keccak_pkg.sv
// Keccak-f[1600] shared definitions
// State geometry, lane and box types, rho rotation offsets,
// iota round constants, round control types, and the
// conversions between the flat bit array and the lane box
package keccak_pkg;

  ////////////////////////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////////////////////////

  // Flat state and lane widths, Keccak-f[1600] only
  localparam int StateW = 1600;
  localparam int LaneW = 64;

  // Keccak-f round count, 12 + 2*log2(LaneW)
  localparam int NumRounds = 24;
  localparam int RndW = 5;

  ////////////////////////////////////////////////////////////
  // State types
  ////////////////////////////////////////////////////////////

  // Flat state, bit LaneW*(5y+x)+z holds (x,y,z)
  typedef logic [StateW-1:0] state_t;

  // One lane along z
  typedef logic [LaneW-1:0] lane_t;

  // Five lanes indexed by x
  typedef lane_t [4:0] plane_t;

  // Full state, indexed [x][y][z]
  typedef lane_t [4:0][4:0] box_t;

  // Rho offsets from FIPS 202 table 2, indexed 5x+y
  // Values above LaneW wrap in the datapath
  localparam int rho_offset [25] = '{
    //  y=0  y=1  y=2  y=3  y=4
        0,   36,  3,   105, 210, // x=0
        1,   300, 10,  45,  66,  // x=1
        190, 6,   171, 15,  253, // x=2
        28,  55,  153, 21,  120, // x=3
        91,  276, 231, 136, 78   // x=4
  };

  // Iota constants, one per round
  localparam lane_t round_const [NumRounds] = '{
    64'h0000_0000_0000_0001, 64'h0000_0000_0000_8082,
    64'h8000_0000_0000_808A, 64'h8000_0000_8000_8000,
    64'h0000_0000_0000_808B, 64'h0000_0000_8000_0001,
    64'h8000_0000_8000_8081, 64'h8000_0000_0000_8009,
    64'h0000_0000_0000_008A, 64'h0000_0000_0000_0088,
    64'h0000_0000_8000_8009, 64'h0000_0000_8000_000A,
    64'h0000_0000_8000_808B, 64'h8000_0000_0000_008B,
    64'h8000_0000_0000_8089, 64'h8000_0000_0000_8003,
    64'h8000_0000_0000_8002, 64'h8000_0000_0000_0080,
    64'h0000_0000_0000_800A, 64'h8000_0000_8000_000A,
    64'h8000_0000_8000_8081, 64'h8000_0000_0000_8080,
    64'h0000_0000_8000_0001, 64'h8000_0000_8000_8008
  };

  ////////////////////////////////////////////////////////////
  // Round control
  ////////////////////////////////////////////////////////////

  typedef enum logic {
    IDLE = 1'b0,
    RUN  = 1'b1
  } ctrl_state_e;

  // Per-cycle control from sequencer to datapath
  typedef struct packed {
    logic            load;    // capture input state
    logic            advance; // capture round result
    logic [RndW-1:0] rnd;     // round index for iota
  } rnd_ctl_t;

  ////////////////////////////////////////////////////////////
  // Conversions
  ////////////////////////////////////////////////////////////

  // Flat array to box, A[x,y,z] = S[w(5y+x)+z]
  function automatic box_t to_box(state_t s);
    box_t b;
    for (int y = 0; y < 5; y++) begin
      for (int x = 0; x < 5; x++) begin
        b[x][y] = s[LaneW*(5*y+x) +: LaneW];
      end
    end
    return b;
  endfunction

  // Box back to flat array
  function automatic state_t to_state(box_t b);
    state_t s;
    for (int y = 0; y < 5; y++) begin
      for (int x = 0; x < 5; x++) begin
        s[LaneW*(5*y+x) +: LaneW] = b[x][y];
      end
    end
    return s;
  endfunction

endpackage
